/* source/gmii_rx_settings.svh */
`ifndef GMII_RX_SETTINGS_SVH
`define GMII_RX_SETTINGS_SVH

// ------------------------------
// Header byte offsets
// ------------------------------
// Counted from the first preamble byte (offset 0)
`define GMII_OFS_ETH_TYPE   20  // EtherType, 2 bytes, big-endian
`define GMII_OFS_IP_VER     22  // IPv4 version/IHL
`define GMII_OFS_IP_PROTO   31  // IPv4 protocol
`define GMII_OFS_UDP_DST    44  // UDP destination port, big-endian
`define GMII_OFS_X_INFO     50  // Start x, little-endian
`define GMII_OFS_Y_INFO     52  // Start y, little-endian
`define GMII_OFS_PAYLOAD    54  // First pixel byte

// ------------------------------
// Match values
// ------------------------------
`define GMII_ETH_TYPE_IPV4  16'h0800
`define GMII_IP_VER_IHL     8'h45   // IPv4, 20-byte header
`define GMII_IP_PROTO_UDP   8'h11
`define GMII_UDP_PORT       16'h3039  // 12345

// Frame byte offset counter width
`define GMII_OFS_WIDTH      11

`endif

/* source/gmii_rx_pkg.sv */
`default_nettype none

`include "gmii_rx_settings.svh"

package gmii_rx_pkg;

  // ------------------------------
  // Stream and header types
  // ------------------------------
  typedef logic [7:0]  gmii_byte_t;   // One GMII data byte
  typedef logic [15:0] half_word_t;   // Type, port, coordinate word

  // Position within the frame, saturating counter
  typedef logic [`GMII_OFS_WIDTH-1:0] byte_offset_t;

  // ------------------------------
  // Pixel types
  // ------------------------------
  typedef logic [11:0] coord_t;       // Screen coordinate
  typedef logic [23:0] rgb_t;         // Three payload bytes

  // Output word, y on top, bytes at the bottom
  typedef struct packed {
    coord_t y;
    coord_t x;
    rgb_t   rgb;   // First payload byte in [23:16]
  } pixel_word_t;

endpackage

`default_nettype wire

/* source/header_field_latch.sv */
`default_nettype none

module header_field_latch #(
  parameter type field_t       = gmii_rx_pkg::gmii_byte_t,
  parameter int  OFFSET        = 0,
  parameter bit  LITTLE_ENDIAN = 1'b0
) (
  input  logic                      clk125,
  input  logic                      sys_rst,
  input  gmii_rx_pkg::byte_offset_t byte_offset,
  input  gmii_rx_pkg::gmii_byte_t   rxd,
  input  logic                      rx_dv,
  output field_t                    field
);
  import gmii_rx_pkg::*;

  localparam int WIDTH  = $bits(field_t);
  localparam int NBYTES = WIDTH / 8;   // Whole bytes only

  byte_offset_t     rel;        // Byte index inside the field
  logic             in_field;   // Current byte belongs to this field
  logic             last_byte;
  logic [WIDTH-1:0] acc;        // Bytes gathered so far
  logic [WIDTH-1:0] acc_nxt;

  assign rel       = byte_offset - byte_offset_t'(OFFSET);
  assign in_field  = rx_dv && (byte_offset >= byte_offset_t'(OFFSET)) &&
                     (rel < byte_offset_t'(NBYTES));
  assign last_byte = (rel == byte_offset_t'(NBYTES - 1));

  // Drop the incoming byte into its lane
  always_comb begin
    acc_nxt = acc;
    for (int i = 0; i < NBYTES; i++) begin
      if (rel == byte_offset_t'(i)) begin
        if (LITTLE_ENDIAN)
          acc_nxt[8*i +: 8] = rxd;              // LSB first
        else
          acc_nxt[8*(NBYTES-1-i) +: 8] = rxd;   // MSB first
      end
    end
  end

  always_ff @(posedge clk125) begin
    if (in_field)
      acc <= acc_nxt;
  end

  // Whole field commits on its last byte, held until next frame
  always_ff @(posedge clk125) begin
    if (sys_rst)
      field <= field_t'('0);
    else if (in_field && last_byte)
      field <= field_t'(acc_nxt);
  end

endmodule

`default_nettype wire

/* source/udp_header_filter.sv */
`default_nettype none

`include "gmii_rx_settings.svh"

module udp_header_filter (
  input  logic                      clk125,
  input  logic                      sys_rst,
  input  gmii_rx_pkg::byte_offset_t byte_offset,
  input  gmii_rx_pkg::gmii_byte_t   rxd,
  input  logic                      rx_dv,
  output logic                      udp_accept,
  output gmii_rx_pkg::coord_t       x_origin,
  output gmii_rx_pkg::coord_t       y_origin
);
  import gmii_rx_pkg::*;

  // Last header byte, y high byte
  localparam byte_offset_t ACCEPT_OFS = byte_offset_t'(`GMII_OFS_PAYLOAD - 1);

  half_word_t eth_type;
  gmii_byte_t ip_ver;
  gmii_byte_t ip_proto;
  half_word_t udp_dst;
  half_word_t x_word;    // Start x as sent
  half_word_t y_word;    // Start y as sent
  logic       hdr_match;

  // ------------------------------
  // Field captures
  // ------------------------------
  header_field_latch #(
    .field_t(half_word_t), .OFFSET(`GMII_OFS_ETH_TYPE), .LITTLE_ENDIAN(1'b0)
  ) eth_type_i (
    .clk125, .sys_rst, .byte_offset, .rxd, .rx_dv, .field(eth_type)
  );

  header_field_latch #(
    .field_t(gmii_byte_t), .OFFSET(`GMII_OFS_IP_VER), .LITTLE_ENDIAN(1'b0)
  ) ip_ver_i (
    .clk125, .sys_rst, .byte_offset, .rxd, .rx_dv, .field(ip_ver)
  );

  header_field_latch #(
    .field_t(gmii_byte_t), .OFFSET(`GMII_OFS_IP_PROTO), .LITTLE_ENDIAN(1'b0)
  ) ip_proto_i (
    .clk125, .sys_rst, .byte_offset, .rxd, .rx_dv, .field(ip_proto)
  );

  header_field_latch #(
    .field_t(half_word_t), .OFFSET(`GMII_OFS_UDP_DST), .LITTLE_ENDIAN(1'b0)
  ) udp_dst_i (
    .clk125, .sys_rst, .byte_offset, .rxd, .rx_dv, .field(udp_dst)
  );

  // Coordinates arrive little-endian
  header_field_latch #(
    .field_t(half_word_t), .OFFSET(`GMII_OFS_X_INFO), .LITTLE_ENDIAN(1'b1)
  ) x_word_i (
    .clk125, .sys_rst, .byte_offset, .rxd, .rx_dv, .field(x_word)
  );

  header_field_latch #(
    .field_t(half_word_t), .OFFSET(`GMII_OFS_Y_INFO), .LITTLE_ENDIAN(1'b1)
  ) y_word_i (
    .clk125, .sys_rst, .byte_offset, .rxd, .rx_dv, .field(y_word)
  );

  // ------------------------------
  // Accept decision
  // ------------------------------
  assign hdr_match = (eth_type == `GMII_ETH_TYPE_IPV4) &&
                     (ip_ver   == `GMII_IP_VER_IHL)    &&
                     (ip_proto == `GMII_IP_PROTO_UDP)  &&
                     (udp_dst  == `GMII_UDP_PORT);

  always_ff @(posedge clk125) begin
    if (sys_rst) begin
      udp_accept <= 1'b0;
    end else if (rx_dv) begin
      if (byte_offset == '0)
        udp_accept <= 1'b0;        // New frame, forget the old verdict
      else if (byte_offset == ACCEPT_OFS)
        udp_accept <= hdr_match;   // Held through the payload
    end
  end

  // Only 12 bits of each coordinate are used
  assign x_origin = x_word[11:0];
  assign y_origin = y_word[11:0];

endmodule

`default_nettype wire

/* source/payload_byte_gather.sv */
`default_nettype none

`include "gmii_rx_settings.svh"

module payload_byte_gather (
  input  logic                      clk125,
  input  logic                      sys_rst,
  input  gmii_rx_pkg::byte_offset_t byte_offset,
  input  gmii_rx_pkg::gmii_byte_t   rxd,
  input  logic                      rx_dv,
  output gmii_rx_pkg::rgb_t         rgb,
  output logic                      rgb_valid
);

  logic [1:0] phase;          // Bytes already held of the current triplet
  logic       payload_byte;   // Valid byte past the header

  assign payload_byte = rx_dv &&
                        (byte_offset >= `GMII_OFS_WIDTH'(`GMII_OFS_PAYLOAD));

  // ------------------------------
  // Triplet phase and strobe
  // ------------------------------
  always_ff @(posedge clk125) begin
    if (sys_rst) begin
      phase     <= 2'd0;
      rgb_valid <= 1'b0;
    end else begin
      rgb_valid <= 1'b0;            // Single-cycle strobe
      if (!rx_dv) begin
        phase <= 2'd0;              // Partial triplet dropped
      end else if (payload_byte) begin
        if (phase == 2'd2) begin
          phase     <= 2'd0;
          rgb_valid <= 1'b1;        // Third byte in
        end else begin
          phase <= phase + 2'd1;
        end
      end
    end
  end

  // ------------------------------
  // Byte shifter
  // ------------------------------
  // First byte ends up in [23:16]
  always_ff @(posedge clk125) begin
    if (payload_byte)
      rgb <= {rgb[15:0], rxd};
  end

endmodule

`default_nettype wire

/* source/pixel_word_former.sv */
`default_nettype none

module pixel_word_former (
  input  logic                     clk125,
  input  logic                     sys_rst,
  input  logic                     udp_accept,
  input  gmii_rx_pkg::coord_t      x_origin,
  input  gmii_rx_pkg::coord_t      y_origin,
  input  gmii_rx_pkg::rgb_t        rgb,
  input  logic                     rgb_valid,
  output gmii_rx_pkg::pixel_word_t datain,
  output logic                     recv_en
);
  import gmii_rx_pkg::*;

  coord_t      pix_idx;    // Pixels emitted in this frame
  logic        emit;       // Triplet of an accepted frame
  pixel_word_t word_nxt;

  assign emit = rgb_valid && udp_accept;

  // ------------------------------
  // Word assembly
  // ------------------------------
  always_comb begin
    word_nxt.y   = y_origin;
    word_nxt.x   = x_origin + pix_idx;   // Wraps at 4096
    word_nxt.rgb = rgb;
  end

  // ------------------------------
  // Pixel index
  // ------------------------------
  always_ff @(posedge clk125) begin
    if (sys_rst) begin
      pix_idx <= '0;
    end else if (!udp_accept) begin
      pix_idx <= '0;               // Idle or rejected frame
    end else if (emit) begin
      pix_idx <= pix_idx + 1'b1;
    end
  end

  // ------------------------------
  // Output register
  // ------------------------------
  always_ff @(posedge clk125) begin
    if (sys_rst) begin
      recv_en <= 1'b0;
      datain  <= '0;
    end else begin
      recv_en <= emit;             // One pulse per pixel
      if (emit)
        datain <= word_nxt;        // Held until the next pixel
    end
  end

endmodule

`default_nettype wire

/* source/gmii2fifo24.sv */
`default_nettype none

module gmii2fifo24 (
  input  logic                     clk125,
  input  logic                     sys_rst,
  input  gmii_rx_pkg::gmii_byte_t  rxd,
  input  logic                     rx_dv,
  output gmii_rx_pkg::pixel_word_t datain,
  output logic                     recv_en
);
  import gmii_rx_pkg::*;

  localparam byte_offset_t OFS_MAX = '1;   // Saturation point

  byte_offset_t ofs_cnt;       // Offset of the next byte
  byte_offset_t byte_offset;   // Offset of the byte on rxd
  logic         udp_accept;
  coord_t       x_origin;
  coord_t       y_origin;
  rgb_t         rgb;
  logic         rgb_valid;

  // ------------------------------
  // Frame byte offset counter
  // ------------------------------
  // Zero whenever rx_dv is low
  assign byte_offset = rx_dv ? ofs_cnt : '0;

  always_ff @(posedge clk125) begin
    if (sys_rst) begin
      // Frame cut by reset is skipped until rx_dv drops
      ofs_cnt <= rx_dv ? OFS_MAX : '0;
    end else if (!rx_dv) begin
      ofs_cnt <= '0;
    end else if (ofs_cnt != OFS_MAX) begin
      ofs_cnt <= ofs_cnt + 1'b1;
    end
  end

  // ------------------------------
  // Header filter and payload side
  // ------------------------------
  udp_header_filter udp_header_filter_i (
    .clk125      (clk125),
    .sys_rst     (sys_rst),
    .byte_offset (byte_offset),
    .rxd         (rxd),
    .rx_dv       (rx_dv),
    .udp_accept  (udp_accept),
    .x_origin    (x_origin),
    .y_origin    (y_origin)
  );

  payload_byte_gather payload_byte_gather_i (
    .clk125      (clk125),
    .sys_rst     (sys_rst),
    .byte_offset (byte_offset),
    .rxd         (rxd),
    .rx_dv       (rx_dv),
    .rgb         (rgb),
    .rgb_valid   (rgb_valid)
  );

  // Output stage, two cycles behind the third byte
  pixel_word_former pixel_word_former_i (
    .clk125      (clk125),
    .sys_rst     (sys_rst),
    .udp_accept  (udp_accept),
    .x_origin    (x_origin),
    .y_origin    (y_origin),
    .rgb         (rgb),
    .rgb_valid   (rgb_valid),
    .datain      (datain),
    .recv_en     (recv_en)
  );

endmodule

`default_nettype wire

/* testbench/gmii2fifo24_chk.sv */
`default_nettype none

module gmii2fifo24_chk (
  input logic clk125,
  input logic sys_rst,
  input logic recv_en
);
  timeunit 1ns;
  timeprecision 1ps;

  int assert_fails = 0;   // Watched from the testbench

  // ------------------------------
  // Output strobe
  // ------------------------------
  single_cycle_pulse: assert property (@(posedge clk125) recv_en |=> !recv_en)
    else begin
      assert_fails++;
      $error("recv_en high on two consecutive cycles");
    end

  // Reset clears the strobe
  quiet_after_reset: assert property (@(posedge clk125) sys_rst |=> !recv_en)
    else begin
      assert_fails++;
      $error("recv_en high in the cycle after sys_rst");
    end

  // One pixel per three bytes at most
  pulse_spacing: assert property (@(posedge clk125) disable iff (sys_rst)
                                  recv_en |=> !recv_en ##1 !recv_en)
    else begin
      assert_fails++;
      $error("recv_en pulses closer than 3 cycles");
    end

endmodule

`default_nettype wire

/* testbench/tb_gmii2fifo24.sv */
`default_nettype none

`include "gmii_rx_settings.svh"

module tb_gmii2fifo24;
  timeunit 1ns;
  timeprecision 1ps;

  import gmii_rx_pkg::*;

  localparam int SEED            = 77;
  localparam int N_RANDOM        = 20;   // Random accepted frames
  localparam int MAX_PAYLOAD     = 60;
  localparam int GAP_CYCLES      = 12;   // Idle cycles between frames
  localparam int RESET_CYCLES    = 2;
  localparam int NUM_FRAMES      = 13 + N_RANDOM;
  localparam int MAX_FRAME_BYTES = `GMII_OFS_PAYLOAD + MAX_PAYLOAD;
  localparam int TIMEOUT_CYCLES  = RESET_CYCLES +
                                   NUM_FRAMES * (MAX_FRAME_BYTES + GAP_CYCLES) + 100;

  typedef gmii_byte_t  byte_q_t[$];
  typedef pixel_word_t word_q_t[$];

  logic        clk125 = 1'b0;
  logic        sys_rst;
  gmii_byte_t  rxd;
  logic        rx_dv;
  pixel_word_t datain;
  logic        recv_en;

  pixel_word_t expected_q[$];     // Words still owed by the DUT
  int          words_seen = 0;    // recv_en pulses so far
  int          cycle_cnt  = 0;

  always #50 clk125 = ~clk125;    // 100 ns period

  gmii2fifo24 gmii2fifo24_i (
    .clk125  (clk125),
    .sys_rst (sys_rst),
    .rxd     (rxd),
    .rx_dv   (rx_dv),
    .datain  (datain),
    .recv_en (recv_en)
  );

  bind gmii2fifo24 gmii2fifo24_chk gmii2fifo24_chk_i (
    .clk125  (clk125),
    .sys_rst (sys_rst),
    .recv_en (recv_en)
  );

  // ------------------------------
  // Failure and compare helpers
  // ------------------------------
  task automatic fail_stop(input string what);
    $display("%s", what);
    $display("tests failed");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input pixel_word_t got, input pixel_word_t exp);
    if (got !== exp)
      fail_stop($sformatf("mismatch %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got !== exp)
      fail_stop($sformatf("mismatch %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  // ------------------------------
  // Frame builder and reference
  // ------------------------------
  function automatic byte_q_t build_frame(input half_word_t eth_type, input gmii_byte_t ip_ver,
                                          input gmii_byte_t ip_proto, input half_word_t port,
                                          input half_word_t x_word, input half_word_t y_word,
                                          input int payload_len);
    byte_q_t frame;
    frame = {};
    for (int i = 0; i < `GMII_OFS_PAYLOAD; i++)
      frame.push_back(gmii_byte_t'(i * 13 + 5));   // Filler for MACs, lengths, IPs
    for (int i = 0; i < 7; i++)
      frame[i] = 8'h55;                             // Preamble
    frame[7] = 8'hd5;                               // SFD
    frame[`GMII_OFS_ETH_TYPE]     = eth_type[15:8];
    frame[`GMII_OFS_ETH_TYPE + 1] = eth_type[7:0];
    frame[`GMII_OFS_IP_VER]       = ip_ver;
    frame[`GMII_OFS_IP_PROTO]     = ip_proto;
    frame[`GMII_OFS_UDP_DST]      = port[15:8];
    frame[`GMII_OFS_UDP_DST + 1]  = port[7:0];
    frame[`GMII_OFS_X_INFO]       = x_word[7:0];    // Little-endian
    frame[`GMII_OFS_X_INFO + 1]   = x_word[15:8];
    frame[`GMII_OFS_Y_INFO]       = y_word[7:0];
    frame[`GMII_OFS_Y_INFO + 1]   = y_word[15:8];
    for (int i = 0; i < payload_len; i++)
      frame.push_back(gmii_byte_t'($urandom));
    return frame;
  endfunction

  function automatic byte_q_t accepted_frame(input half_word_t x_word, input half_word_t y_word,
                                             input int payload_len);
    return build_frame(`GMII_ETH_TYPE_IPV4, `GMII_IP_VER_IHL, `GMII_IP_PROTO_UDP,
                       `GMII_UDP_PORT, x_word, y_word, payload_len);
  endfunction

  // Expected pixel words of one whole frame
  function automatic word_q_t ref_words(input byte_q_t frame);
    word_q_t     words;
    half_word_t  x_word;
    half_word_t  y_word;
    logic        accept;
    int          n;
    int          p;
    pixel_word_t w;
    words  = {};
    accept = (frame.size() >= `GMII_OFS_PAYLOAD);
    if (accept) begin
      accept = ({frame[`GMII_OFS_ETH_TYPE], frame[`GMII_OFS_ETH_TYPE + 1]} ==
                `GMII_ETH_TYPE_IPV4) &&
               (frame[`GMII_OFS_IP_VER] == `GMII_IP_VER_IHL) &&
               (frame[`GMII_OFS_IP_PROTO] == `GMII_IP_PROTO_UDP) &&
               ({frame[`GMII_OFS_UDP_DST], frame[`GMII_OFS_UDP_DST + 1]} == `GMII_UDP_PORT);
    end
    if (accept) begin
      x_word = {frame[`GMII_OFS_X_INFO + 1], frame[`GMII_OFS_X_INFO]};
      y_word = {frame[`GMII_OFS_Y_INFO + 1], frame[`GMII_OFS_Y_INFO]};
      n      = (frame.size() - `GMII_OFS_PAYLOAD) / 3;    // Partial triplet dropped
      for (int k = 0; k < n; k++) begin
        p     = `GMII_OFS_PAYLOAD + 3 * k;
        w.y   = y_word[11:0];
        w.x   = coord_t'(int'(x_word[11:0]) + k);         // 12-bit wrap
        w.rgb = {frame[p], frame[p + 1], frame[p + 2]};   // First byte on top
        words.push_back(w);
      end
    end
    return words;
  endfunction

  // ------------------------------
  // Frame driver
  // ------------------------------
  // reset_idx below zero means no reset inside the frame
  task automatic send_frame(input byte_q_t frame, input int reset_idx);
    word_q_t exp_words;
    int      keep;
    int      start_seen;
    exp_words = ref_words(frame);
    keep      = exp_words.size();
    if (reset_idx >= 0) begin
      // Only pulses landing before the reset edge survive
      keep = 0;
      while (keep < exp_words.size() && `GMII_OFS_PAYLOAD + 3 * keep + 3 < reset_idx)
        keep++;
    end
    for (int i = 0; i < keep; i++)
      expected_q.push_back(exp_words[i]);
    start_seen = words_seen;
    foreach (frame[i]) begin
      @(negedge clk125);
      rx_dv   = 1'b1;
      rxd     = frame[i];
      sys_rst = (reset_idx >= 0) && (i >= reset_idx) && (i < reset_idx + RESET_CYCLES);
    end
    repeat (GAP_CYCLES) begin
      @(negedge clk125);
      rx_dv   = 1'b0;
      rxd     = '0;
      sys_rst = 1'b0;
    end
    check_count("recv_en", words_seen - start_seen, keep);   // Words for this frame
  endtask

  // ------------------------------
  // Compare process
  // ------------------------------
  initial begin : compare_words
    pixel_word_t exp_word;
    forever begin
      @(negedge clk125);                     // Outputs settled since posedge
      if (recv_en === 1'b1) begin
        if (expected_q.size() == 0) begin
          fail_stop("recv_en pulsed while no pixel word was expected");
        end else begin
          exp_word = expected_q.pop_front();
          check_word("datain", datain, exp_word);
          words_seen++;
        end
      end
    end
  end

  // Cycle limit and assertion watch
  initial begin : watchdog
    forever begin
      @(negedge clk125);
      cycle_cnt++;
      if (gmii2fifo24_i.gmii2fifo24_chk_i.assert_fails != 0)
        fail_stop("an assertion in gmii2fifo24_chk failed");
      else if (cycle_cnt >= TIMEOUT_CYCLES)
        fail_stop($sformatf("timeout after %0d cycles", cycle_cnt));
    end
  end

  // ------------------------------
  // Test sequence
  // ------------------------------
  initial begin : run_tests
    byte_q_t    frame;
    half_word_t x_rand;
    half_word_t y_rand;
    int         plen;
    void'($urandom(SEED));
    rxd     = '0;
    rx_dv   = 1'b0;
    sys_rst = 1'b1;
    repeat (RESET_CYCLES) @(negedge clk125);
    sys_rst = 1'b0;

    // Three pixels, known bytes
    frame = accepted_frame(16'h0123, 16'h0456, 9);
    for (int i = 0; i < 9; i++)
      frame[`GMII_OFS_PAYLOAD + i] = 8'ha0 + 8'(i);
    send_frame(frame, -1);

    // One wrong field each
    send_frame(build_frame(16'h0806, `GMII_IP_VER_IHL, `GMII_IP_PROTO_UDP, `GMII_UDP_PORT,
                           16'd10, 16'd20, 6), -1);
    send_frame(build_frame(`GMII_ETH_TYPE_IPV4, 8'h46, `GMII_IP_PROTO_UDP, `GMII_UDP_PORT,
                           16'd10, 16'd20, 6), -1);
    send_frame(build_frame(`GMII_ETH_TYPE_IPV4, `GMII_IP_VER_IHL, 8'h06, `GMII_UDP_PORT,
                           16'd10, 16'd20, 6), -1);
    send_frame(build_frame(`GMII_ETH_TYPE_IPV4, `GMII_IP_VER_IHL, `GMII_IP_PROTO_UDP,
                           16'h3038, 16'd10, 16'd20, 6), -1);

    // Trailing partial triplets
    send_frame(accepted_frame(16'd5, 16'd6, 10), -1);
    send_frame(accepted_frame(16'd7, 16'd8, 14), -1);

    // Back to back and accepted before rejected
    send_frame(accepted_frame(16'd100, 16'd20, 6), -1);
    send_frame(accepted_frame(16'd7, 16'd300, 6), -1);
    send_frame(accepted_frame(16'h0ffe, 16'h0fff, 9), -1);    // x wraps here
    send_frame(build_frame(`GMII_ETH_TYPE_IPV4, `GMII_IP_VER_IHL, `GMII_IP_PROTO_UDP,
                           16'h3039 ^ 16'h0100, 16'd1, 16'd1, 9), -1);

    // Random accepted frames
    for (int k = 0; k < N_RANDOM; k++) begin
      x_rand = half_word_t'($urandom);
      y_rand = half_word_t'($urandom);
      if (k % 3 == 0)
        x_rand[11:0] = 12'hff0 + 12'($urandom_range(0, 15));   // Near the top
      plen = (k == 0) ? MAX_PAYLOAD : int'($urandom_range(0, MAX_PAYLOAD));
      send_frame(accepted_frame(x_rand, y_rand, plen), -1);
    end

    // Reset in the middle of the payload with whole triplets still to come
    send_frame(accepted_frame(16'd50, 16'd60, 24), `GMII_OFS_PAYLOAD + 8);
    send_frame(accepted_frame(16'd1, 16'd2, 6), -1);

    if (expected_q.size() == 0) begin
      $display("all tests passed");
      $finish;
    end else begin
      fail_stop("expected pixel words never arrived");
    end
  end

endmodule

`default_nettype wire

/* compile.f */
+incdir+source
source/gmii_rx_pkg.sv
source/header_field_latch.sv
source/udp_header_filter.sv
source/payload_byte_gather.sv
source/pixel_word_former.sv
source/gmii2fifo24.sv
testbench/gmii2fifo24_chk.sv
testbench/tb_gmii2fifo24.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the gmii2fifo24 testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module tb_gmii2fifo24 -Mdir obj_dir -f compile.f

# Simulator exit status is kept aside, the output decides
sim_out=$(./obj_dir/Vtb_gmii2fifo24 +verilator+error+limit+100 2>&1) || true
printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -qx "all tests passed"; then
  exit 0
else
  echo "simulation did not pass"
  exit 1
fi
